// ==== include/riscv_lite_params.svh ====
`ifndef RISCV_LITE_PARAMS_SVH
`define RISCV_LITE_PARAMS_SVH

// data and address width
`define RV_XLEN 32

// architectural integer registers
`define RV_NREGS 32

// first fetch address
`define RV_RESET_PC 32'h0000_0000

`endif

// ==== hdl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    // register-register format
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // register-immediate format
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // upper immediate format
    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // one instruction word, three views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        u_fmt_t u_fmt;
    } inst_u;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;

endpackage

`default_nettype wire

// ==== hdl/pipe_pkg.sv ====
`default_nettype none
`include "riscv_lite_params.svh"

package pipe_pkg;

    localparam int REG_AW = $clog2(`RV_NREGS);

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        // operand b straight through, for lui
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        logic [REG_AW-1:0]   rs1;
        logic [REG_AW-1:0]   rs2;
        logic [REG_AW-1:0]   rd;
        logic                use_imm;
        logic [`RV_XLEN-1:0] imm;
        alu_op_e             alu_op;
        logic                we;
    } exec_op_t;

endpackage

`default_nettype wire

// ==== hdl/exec_if.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "riscv_lite_params.svh"

interface exec_if;

    logic                valid;
    logic [`RV_XLEN-1:0] pc;
    // raw word kept for the commit report
    logic [`RV_XLEN-1:0] inst;
    pipe_pkg::exec_op_t  op;

    modport dec (
        output valid,
        output pc,
        output inst,
        output op
    );

    modport exe (
        input valid,
        input pc,
        input inst,
        input op
    );

endinterface

`default_nettype wire

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "riscv_lite_params.svh"

module fetch_unit (
    input  wire logic                clk,
    input  wire logic                rst,
    output logic                     ireq_valid,
    output logic [`RV_XLEN-1:0]      ireq_addr,
    input  wire logic                iresp_valid,
    input  wire logic [`RV_XLEN-1:0] iresp_data,
    output logic                     fetch_valid,
    output logic [`RV_XLEN-1:0]      fetch_pc,
    output logic [`RV_XLEN-1:0]      fetch_inst
);

    logic [`RV_XLEN-1:0] pc_q;
    logic                outstanding_q;
    logic                outstanding_d;
    logic                req_q;

    // a request stays open from its strobe until the response
    assign outstanding_d = (outstanding_q | req_q) & ~iresp_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_q          <= `RV_RESET_PC;
            outstanding_q <= 1'b0;
            req_q         <= 1'b0;
        end else begin
            outstanding_q <= outstanding_d;
            // next request as soon as the bus is idle
            req_q         <= ~outstanding_d;
            if (iresp_valid) begin
                pc_q <= pc_q + `RV_XLEN'd4;
            end
        end
    end

    assign ireq_valid = req_q;
    assign ireq_addr  = pc_q;

    // pc only moves at the response edge, so it still names this word
    assign fetch_valid = iresp_valid;
    assign fetch_pc    = pc_q;
    assign fetch_inst  = iresp_data;

    a_resp_outstanding: assert property (
        @(posedge clk) disable iff (rst)
        iresp_valid |-> outstanding_q
    );

    a_single_request: assert property (
        @(posedge clk) disable iff (rst)
        ireq_valid |=> !ireq_valid until_with iresp_valid
    );

endmodule

`default_nettype wire

// ==== hdl/decode_stage.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "riscv_lite_params.svh"

module decode_stage (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                fetch_valid,
    input  wire logic [`RV_XLEN-1:0] fetch_pc,
    input  wire logic [`RV_XLEN-1:0] fetch_inst,
    exec_if.dec                      exe
);

    isa_pkg::inst_u     inst;
    pipe_pkg::exec_op_t op_d;
    logic               supported;
    logic               base_f7;

    assign inst    = fetch_inst;
    assign base_f7 = (inst.r_fmt.funct7 == isa_pkg::F7_BASE);

    always_comb begin
        op_d      = '0;
        supported = 1'b0;
        // rd sits in the same bits in every format
        op_d.rd   = inst.r_fmt.rd;
        case (inst.r_fmt.opcode)
            isa_pkg::OPC_OP: begin
                op_d.rs1     = inst.r_fmt.rs1;
                op_d.rs2     = inst.r_fmt.rs2;
                op_d.use_imm = 1'b0;
                case (inst.r_fmt.funct3)
                    isa_pkg::F3_ADD_SUB: begin
                        if (base_f7) begin
                            op_d.alu_op = pipe_pkg::ALU_ADD;
                            supported   = 1'b1;
                        end else if (inst.r_fmt.funct7 == isa_pkg::F7_SUB) begin
                            op_d.alu_op = pipe_pkg::ALU_SUB;
                            supported   = 1'b1;
                        end
                    end
                    isa_pkg::F3_XOR: begin
                        op_d.alu_op = pipe_pkg::ALU_XOR;
                        supported   = base_f7;
                    end
                    isa_pkg::F3_OR: begin
                        op_d.alu_op = pipe_pkg::ALU_OR;
                        supported   = base_f7;
                    end
                    isa_pkg::F3_AND: begin
                        op_d.alu_op = pipe_pkg::ALU_AND;
                        supported   = base_f7;
                    end
                    default: supported = 1'b0;
                endcase
            end
            isa_pkg::OPC_OP_IMM: begin
                op_d.rs1     = inst.i_fmt.rs1;
                op_d.use_imm = 1'b1;
                op_d.imm     = {{(`RV_XLEN-12){inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
                supported    = 1'b1;
                case (inst.i_fmt.funct3)
                    isa_pkg::F3_ADD_SUB: op_d.alu_op = pipe_pkg::ALU_ADD;
                    isa_pkg::F3_XOR:     op_d.alu_op = pipe_pkg::ALU_XOR;
                    isa_pkg::F3_OR:      op_d.alu_op = pipe_pkg::ALU_OR;
                    isa_pkg::F3_AND:     op_d.alu_op = pipe_pkg::ALU_AND;
                    // slti, shifts and friends are not in this core
                    default:             supported   = 1'b0;
                endcase
            end
            isa_pkg::OPC_LUI: begin
                op_d.use_imm = 1'b1;
                op_d.imm     = {inst.u_fmt.imm20, 12'b0};
                op_d.alu_op  = pipe_pkg::ALU_PASS_B;
                supported    = 1'b1;
            end
            default: supported = 1'b0;
        endcase
        op_d.we = supported && (op_d.rd != '0);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exe.valid <= 1'b0;
            exe.pc    <= '0;
            exe.inst  <= '0;
            exe.op    <= '0;
        end else begin
            exe.valid <= fetch_valid;
            if (fetch_valid) begin
                exe.pc   <= fetch_pc;
                exe.inst <= fetch_inst;
                exe.op   <= op_d;
            end
        end
    end

    // registered record must agree with the raw word it came from
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (rst)
        exe.valid && exe.op.we |-> exe.inst[11:7] != 5'd0
    );

endmodule

`default_nettype wire

// ==== hdl/execute_stage.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "riscv_lite_params.svh"

module execute_stage (
    input  wire logic                    clk,
    input  wire logic                    rst,
    exec_if.exe                          exe,
    output logic                         commit_valid,
    output logic [`RV_XLEN-1:0]          commit_pc,
    output logic [`RV_XLEN-1:0]          commit_inst,
    output logic                         commit_we,
    output logic [pipe_pkg::REG_AW-1:0]  commit_rd,
    output logic [`RV_XLEN-1:0]          commit_wdata
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];
    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;
    logic [`RV_XLEN-1:0] opnd_b;
    logic [`RV_XLEN-1:0] result;

    // x0 reads as zero
    assign rs1_val = (exe.op.rs1 == '0) ? '0 : regs[exe.op.rs1];
    assign rs2_val = (exe.op.rs2 == '0) ? '0 : regs[exe.op.rs2];
    assign opnd_b  = exe.op.use_imm ? exe.op.imm : rs2_val;

    always_comb begin
        case (exe.op.alu_op)
            pipe_pkg::ALU_ADD:    result = rs1_val + opnd_b;
            pipe_pkg::ALU_SUB:    result = rs1_val - opnd_b;
            pipe_pkg::ALU_AND:    result = rs1_val & opnd_b;
            pipe_pkg::ALU_OR:     result = rs1_val | opnd_b;
            pipe_pkg::ALU_XOR:    result = rs1_val ^ opnd_b;
            pipe_pkg::ALU_PASS_B: result = opnd_b;
            default:              result = '0;
        endcase
    end

    // writeback and commit report share one edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
            commit_valid <= 1'b0;
            commit_pc    <= '0;
            commit_inst  <= '0;
            commit_we    <= 1'b0;
            commit_rd    <= '0;
            commit_wdata <= '0;
        end else begin
            commit_valid <= exe.valid;
            if (exe.valid) begin
                commit_pc    <= exe.pc;
                commit_inst  <= exe.inst;
                commit_we    <= exe.op.we;
                commit_rd    <= exe.op.rd;
                commit_wdata <= result;
                if (exe.op.we) begin
                    regs[exe.op.rd] <= result;
                end
            end
        end
    end

    a_x0_stays_zero: assert property (
        @(posedge clk) disable iff (rst)
        regs[0] == '0
    );

endmodule

`default_nettype wire

// ==== hdl/riscv_lite.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "riscv_lite_params.svh"

module riscv_lite (
    input  wire logic                    clk,
    input  wire logic                    rst,
    // instruction bus
    output logic                         ireq_valid,
    output logic [`RV_XLEN-1:0]          ireq_addr,
    input  wire logic                    iresp_valid,
    input  wire logic [`RV_XLEN-1:0]     iresp_data,
    // retired instruction report
    output logic                         commit_valid,
    output logic [`RV_XLEN-1:0]          commit_pc,
    output logic [`RV_XLEN-1:0]          commit_inst,
    output logic                         commit_we,
    output logic [pipe_pkg::REG_AW-1:0]  commit_rd,
    output logic [`RV_XLEN-1:0]          commit_wdata
);

    logic                fetch_valid;
    logic [`RV_XLEN-1:0] fetch_pc;
    logic [`RV_XLEN-1:0] fetch_inst;

    exec_if exe_bus ();

    fetch_unit u_fetch (
        .clk         (clk),
        .rst         (rst),
        .ireq_valid  (ireq_valid),
        .ireq_addr   (ireq_addr),
        .iresp_valid (iresp_valid),
        .iresp_data  (iresp_data),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_inst  (fetch_inst)
    );

    decode_stage u_decode (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_inst  (fetch_inst),
        .exe         (exe_bus.dec)
    );

    execute_stage u_execute (
        .clk          (clk),
        .rst          (rst),
        .exe          (exe_bus.exe),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_inst  (commit_inst),
        .commit_we    (commit_we),
        .commit_rd    (commit_rd),
        .commit_wdata (commit_wdata)
    );

endmodule

`default_nettype wire

// ==== tb/imem_model.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "riscv_lite_params.svh"

module imem_model (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                ireq_valid,
    input  wire logic [`RV_XLEN-1:0] ireq_addr,
    output logic                     iresp_valid,
    output logic [`RV_XLEN-1:0]      iresp_data
);

    localparam int PROG_LEN = 19;

    logic [`RV_XLEN-1:0] prog [PROG_LEN];
    logic [`RV_XLEN-1:0] addr_q;
    logic                busy;
    logic [1:0]          wait_cnt;
    integer              seed;
    integer              lat;

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        isa_pkg::inst_u w;
        w.r_fmt = '{f7, rs2, rs1, f3, rd, isa_pkg::OPC_OP};
        return w;
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        isa_pkg::inst_u w;
        w.i_fmt = '{imm, rs1, f3, rd, isa_pkg::OPC_OP_IMM};
        return w;
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        isa_pkg::inst_u w;
        w.u_fmt = '{imm, rd, isa_pkg::OPC_LUI};
        return w;
    endfunction

    // past the program, unsupported words that vary with the address
    function automatic logic [31:0] word_at(input logic [`RV_XLEN-1:0] addr);
        if (addr < 4 * PROG_LEN) begin
            return prog[addr[`RV_XLEN-1:2]];
        end
        return (addr * 32'h9e37_79b1) | 32'h0000_007f;
    endfunction

    initial begin
        seed        = 32'hddb5170b;
        iresp_valid = 1'b0;
        iresp_data  = '0;
        // immediates
        prog[0]  = enc_i(12'h123, 5'd0, isa_pkg::F3_ADD_SUB, 5'd1);
        prog[1]  = enc_i(12'hffb, 5'd0, isa_pkg::F3_ADD_SUB, 5'd2);
        prog[2]  = enc_u(20'h12345, 5'd3);
        prog[3]  = enc_i(12'h0f0, 5'd3, isa_pkg::F3_OR, 5'd4);
        prog[4]  = enc_i(12'h7ff, 5'd2, isa_pkg::F3_XOR, 5'd5);
        prog[5]  = enc_i(12'hf00, 5'd4, isa_pkg::F3_AND, 5'd6);
        prog[6]  = enc_i(12'hfff, 5'd3, isa_pkg::F3_ADD_SUB, 5'd3);
        // dependent chain, each uses the previous result
        prog[7]  = enc_r(isa_pkg::F7_BASE, 5'd2, 5'd1, isa_pkg::F3_ADD_SUB, 5'd7);
        prog[8]  = enc_r(isa_pkg::F7_SUB, 5'd3, 5'd7, isa_pkg::F3_ADD_SUB, 5'd8);
        prog[9]  = enc_r(isa_pkg::F7_BASE, 5'd4, 5'd8, isa_pkg::F3_AND, 5'd9);
        prog[10] = enc_r(isa_pkg::F7_BASE, 5'd5, 5'd9, isa_pkg::F3_OR, 5'd10);
        prog[11] = enc_r(isa_pkg::F7_BASE, 5'd6, 5'd10, isa_pkg::F3_XOR, 5'd11);
        prog[12] = enc_r(isa_pkg::F7_SUB, 5'd11, 5'd11, isa_pkg::F3_ADD_SUB, 5'd12);
        // rd zero, slti, a store, then reads of x0
        prog[13] = enc_i(12'h055, 5'd1, isa_pkg::F3_ADD_SUB, 5'd0);
        prog[14] = enc_r(isa_pkg::F7_BASE, 5'd8, 5'd7, isa_pkg::F3_ADD_SUB, 5'd0);
        prog[15] = enc_i(12'h001, 5'd1, 3'b010, 5'd13);
        prog[16] = 32'h0011_2023;
        prog[17] = enc_r(isa_pkg::F7_BASE, 5'd1, 5'd0, isa_pkg::F3_ADD_SUB, 5'd13);
        prog[18] = enc_i(12'h000, 5'd0, isa_pkg::F3_ADD_SUB, 5'd14);
    end

    // answers 1 to 4 cycles after the request edge
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            iresp_valid <= 1'b0;
            iresp_data  <= '0;
            addr_q      <= '0;
            busy        <= 1'b0;
            wait_cnt    <= '0;
        end else begin
            iresp_valid <= 1'b0;
            if (ireq_valid) begin
                lat      = $random(seed);
                busy     <= 1'b1;
                addr_q   <= ireq_addr;
                wait_cnt <= lat[1:0];
            end else if (busy) begin
                if (wait_cnt == '0) begin
                    iresp_valid <= 1'b1;
                    iresp_data  <= word_at(addr_q);
                    busy        <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_riscv_lite.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "riscv_lite_params.svh"

module tb_riscv_lite;

    localparam int WAIT_LIMIT = 200;

    logic                        clk = 1'b0;
    logic                        rst;
    logic                        ireq_valid;
    logic [`RV_XLEN-1:0]         ireq_addr;
    logic                        iresp_valid;
    logic [`RV_XLEN-1:0]         iresp_data;
    logic                        commit_valid;
    logic [`RV_XLEN-1:0]         commit_pc;
    logic [`RV_XLEN-1:0]         commit_inst;
    logic                        commit_we;
    logic [pipe_pkg::REG_AW-1:0] commit_rd;
    logic [`RV_XLEN-1:0]         commit_wdata;

    logic [`RV_XLEN-1:0] ref_regs [`RV_NREGS];
    logic [`RV_XLEN-1:0] exp_pc;
    logic [`RV_XLEN-1:0] exp_req_addr;
    logic [`RV_XLEN-1:0] resp_word_q1;
    logic [`RV_XLEN-1:0] resp_word_q2;
    logic [`RV_XLEN-1:0] exp_val;
    logic [`RV_XLEN-1:0] rs1_v;
    logic [`RV_XLEN-1:0] rs2_v;
    logic [`RV_XLEN-1:0] imm_i;
    logic [4:0]          exp_rd;
    logic                exp_ok;
    logic                exp_we;
    logic                seen_req;
    logic                req_open;
    logic                timed_out = 1'b0;
    int                  commit_count = 0;
    int                  err_count = 0;
    int                  tests_done = 0;

    always #50 clk = ~clk;

    riscv_lite u_riscv_lite (
        .clk          (clk),
        .rst          (rst),
        .ireq_valid   (ireq_valid),
        .ireq_addr    (ireq_addr),
        .iresp_valid  (iresp_valid),
        .iresp_data   (iresp_data),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_inst  (commit_inst),
        .commit_we    (commit_we),
        .commit_rd    (commit_rd),
        .commit_wdata (commit_wdata)
    );

    imem_model u_imem (
        .clk         (clk),
        .rst         (rst),
        .ireq_valid  (ireq_valid),
        .ireq_addr   (ireq_addr),
        .iresp_valid (iresp_valid),
        .iresp_data  (iresp_data)
    );

    // reference decode straight from the RV32I field layout
    assign exp_rd = commit_inst[11:7];
    assign rs1_v  = ref_regs[commit_inst[19:15]];
    assign rs2_v  = ref_regs[commit_inst[24:20]];
    assign imm_i  = {{20{commit_inst[31]}}, commit_inst[31:20]};

    always_comb begin
        exp_ok  = 1'b0;
        exp_val = '0;
        if (commit_inst[6:0] == 7'b0110111) begin
            exp_ok  = 1'b1;
            exp_val = {commit_inst[31:12], 12'h000};
        end else if (commit_inst[6:0] == 7'b0010011) begin
            exp_ok = 1'b1;
            case (commit_inst[14:12])
                3'b000:  exp_val = rs1_v + imm_i;
                3'b100:  exp_val = rs1_v ^ imm_i;
                3'b110:  exp_val = rs1_v | imm_i;
                3'b111:  exp_val = rs1_v & imm_i;
                default: exp_ok = 1'b0;
            endcase
        end else if (commit_inst[6:0] == 7'b0110011) begin
            if (commit_inst[31:25] == 7'b0100000 && commit_inst[14:12] == 3'b000) begin
                exp_ok  = 1'b1;
                exp_val = rs1_v - rs2_v;
            end else if (commit_inst[31:25] == 7'b0000000) begin
                exp_ok = 1'b1;
                case (commit_inst[14:12])
                    3'b000:  exp_val = rs1_v + rs2_v;
                    3'b100:  exp_val = rs1_v ^ rs2_v;
                    3'b110:  exp_val = rs1_v | rs2_v;
                    3'b111:  exp_val = rs1_v & rs2_v;
                    default: exp_ok = 1'b0;
                endcase
            end
        end
        exp_we = exp_ok && (exp_rd != 5'd0);
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                ref_regs[i] <= '0;
            end
            exp_pc       <= `RV_RESET_PC;
            exp_req_addr <= `RV_RESET_PC;
            resp_word_q1 <= '0;
            resp_word_q2 <= '0;
            commit_count <= 0;
            seen_req     <= 1'b0;
            req_open     <= 1'b0;
        end else begin
            // memory word delayed to line up with its commit
            resp_word_q1 <= iresp_data;
            resp_word_q2 <= resp_word_q1;
            if (ireq_valid) begin
                seen_req     <= 1'b1;
                req_open     <= 1'b1;
                exp_req_addr <= exp_req_addr + 32'd4;
            end else if (iresp_valid) begin
                req_open <= 1'b0;
            end
            if (commit_valid) begin
                commit_count <= commit_count + 1;
                exp_pc       <= exp_pc + 32'd4;
                if (exp_we) begin
                    ref_regs[exp_rd] <= exp_val;
                end
            end
        end
    end

    a_reset_quiet: assert property (@(posedge clk) rst |-> !ireq_valid && !commit_valid)
        else begin
            err_count++;
            $display("request or commit strobe seen while reset is held");
        end

    // the first request goes to the reset pc, each later one 4 bytes on
    a_req_addr: assert property (
        @(posedge clk) disable iff (rst)
        ireq_valid |-> ireq_addr == exp_req_addr
    ) else begin
        err_count++;
        $display("error: ireq_addr = %h, expected %h",
                 $sampled(ireq_addr), $sampled(exp_req_addr));
    end

    a_one_outstanding: assert property (
        @(posedge clk) disable iff (rst) ireq_valid |-> !req_open
    ) else begin
        err_count++;
        $display("new request issued while another is still outstanding");
    end

    a_resp_has_req: assert property (
        @(posedge clk) disable iff (rst) iresp_valid |-> req_open
    ) else begin
        err_count++;
        $display("response arrived with no request outstanding");
    end

    a_resp_to_commit: assert property (
        @(posedge clk) disable iff (rst) iresp_valid |-> ##2 commit_valid
    ) else begin
        err_count++;
        $display("response not followed by a commit two cycles later");
    end

    a_commit_from_resp: assert property (
        @(posedge clk) disable iff (rst) commit_valid |-> $past(iresp_valid, 2)
    ) else begin
        err_count++;
        $display("commit without a response two cycles before");
    end

    a_commit_pc: assert property (
        @(posedge clk) disable iff (rst) commit_valid |-> commit_pc == exp_pc
    ) else begin
        err_count++;
        $display("error: commit_pc = %h, expected %h", $sampled(commit_pc), $sampled(exp_pc));
    end

    a_commit_inst: assert property (
        @(posedge clk) disable iff (rst) commit_valid |-> commit_inst == resp_word_q2
    ) else begin
        err_count++;
        $display("error: commit_inst = %h, expected %h",
                 $sampled(commit_inst), $sampled(resp_word_q2));
    end

    a_commit_we: assert property (
        @(posedge clk) disable iff (rst) commit_valid |-> commit_we == exp_we
    ) else begin
        err_count++;
        $display("error: commit_we = %h, expected %h", $sampled(commit_we), $sampled(exp_we));
    end

    a_commit_rd: assert property (
        @(posedge clk) disable iff (rst) commit_valid && exp_we |-> commit_rd == exp_rd
    ) else begin
        err_count++;
        $display("error: commit_rd = %h, expected %h", $sampled(commit_rd), $sampled(exp_rd));
    end

    a_commit_wdata: assert property (
        @(posedge clk) disable iff (rst) commit_valid && exp_we |-> commit_wdata == exp_val
    ) else begin
        err_count++;
        $display("error: commit_wdata = %h, expected %h",
                 $sampled(commit_wdata), $sampled(exp_val));
    end

    task automatic wait_first_request();
        int cycles;
        cycles = 0;
        while (!seen_req && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (!seen_req) begin
            timed_out = 1'b1;
            $display("timeout: no instruction request after reset");
        end
    endtask

    task automatic wait_commits(input int target);
        int cycles;
        cycles = 0;
        while (commit_count < target && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (commit_count < target) begin
            timed_out = 1'b1;
            $display("timeout: only %0d of %0d instructions retired", commit_count, target);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_done++;
        $display("test %s: %0d errors", name, err_count - errs_before);
    endtask

    initial begin
        int mark;
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        mark = err_count;
        wait_first_request();
        report_test("reset and first fetch", mark);
        if (!timed_out) begin
            mark = err_count;
            wait_commits(7);
            report_test("immediate ops", mark);
        end
        if (!timed_out) begin
            mark = err_count;
            wait_commits(13);
            report_test("dependent register ops", mark);
        end
        if (!timed_out) begin
            mark = err_count;
            wait_commits(19);
            report_test("x0 and unsupported words", mark);
        end
        if (!timed_out) begin
            mark = err_count;
            wait_commits(24);
            report_test("ordering and latency", mark);
        end
        @(negedge clk);
        $display("%0d tests, %0d instructions retired, %0d errors",
                 tests_done, commit_count, err_count);
        if (err_count == 0 && !timed_out) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== riscv_lite.f ====
+incdir+include
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/exec_if.sv
hdl/fetch_unit.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/riscv_lite.sv
tb/imem_model.sv
tb/tb_riscv_lite.sv

// ==== Bender.yml ====
package:
  name: riscv_lite

sources:
  - include_dirs:
      - include
    files:
      - hdl/isa_pkg.sv
      - hdl/pipe_pkg.sv
      - hdl/exec_if.sv
      - hdl/fetch_unit.sv
      - hdl/decode_stage.sv
      - hdl/execute_stage.sv
      - hdl/riscv_lite.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/imem_model.sv
      - tb/tb_riscv_lite.sv
